//--- vlog.f
mips_pkg.sv
main_control.sv
register_bank.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
tb_mips_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_core
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f vlog.f --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^ALL CHECKS PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

	localparam int          NUM_INSTR   = 2000;
	localparam int          NUM_CYCLES  = NUM_INSTR + 4;
	localparam int          CLK_PERIOD  = 20;
	localparam int          TIMEOUT_NS  = (NUM_INSTR + 20) * CLK_PERIOD + 500;
	// opcode 6'h3f is not decoded so this word is a bubble
	localparam logic [31:0] BUBBLE_WORD = 32'hfc00_0000;

	logic                            i_clk;
	logic                            i_rst_n;
	mips_pkg::instr_t                i_instr;
	logic [mips_pkg::XLEN-1:0]       i_next_pc;
	logic                            o_branch_taken;
	logic [mips_pkg::XLEN-1:0]       o_branch_target;
	logic                            o_wb_en;
	logic [mips_pkg::REG_ADDR_W-1:0] o_wb_reg;
	logic [mips_pkg::XLEN-1:0]       o_wb_data;

	// architectural state of the model
	logic [mips_pkg::XLEN-1:0]       model_regs [2**mips_pkg::REG_ADDR_W];
	logic [mips_pkg::XLEN-1:0]       model_ram [mips_pkg::DMEM_DEPTH];
	// expected outputs indexed by the cycle they are due in
	logic                            exp_wb_en [NUM_CYCLES];
	logic [mips_pkg::REG_ADDR_W-1:0] exp_wb_reg [NUM_CYCLES];
	logic [mips_pkg::XLEN-1:0]       exp_wb_data [NUM_CYCLES];
	logic                            exp_br_taken [NUM_CYCLES];
	logic                            exp_br_valid [NUM_CYCLES];
	logic [mips_pkg::XLEN-1:0]       exp_br_target [NUM_CYCLES];

	logic [31:0] rng_state;
	int          cyc;
	bit          checking;
	int          wb_errors;
	int          br_errors;

	mips_core i_dut (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_instr         (i_instr),
		.i_next_pc       (i_next_pc),
		.o_branch_taken  (o_branch_taken),
		.o_branch_target (o_branch_target),
		.o_wb_en         (o_wb_en),
		.o_wb_reg        (o_wb_reg),
		.o_wb_data       (o_wb_data)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// =========================================================================
	// instruction generator
	// =========================================================================
	function automatic mips_pkg::instr_t make_instr();
		mips_pkg::instr_t w;
		logic [31:0]      r;
		int unsigned      pick;
		r    = next_random();
		pick = next_random() % 100;
		w    = r;
		// registers 0..7 only so dependences show up often
		w.r.rs = {2'b00, r[23:21]};
		w.r.rt = {2'b00, r[18:16]};
		if (pick < 3) begin
			case (r[31:26])
				mips_pkg::OP_RTYPE, mips_pkg::OP_ADDI, mips_pkg::OP_LW,
				mips_pkg::OP_SW, mips_pkg::OP_BEQ: w.r.opcode = 6'h3f;
				default: w.r.opcode = r[31:26];
			endcase
		end else begin
			case (pick % 9)
				0, 1, 2, 3, 4: begin
					w.r.opcode = mips_pkg::OP_RTYPE;
					w.r.rd     = {2'b00, r[13:11]};
					case (pick % 5)
						0: w.r.funct = mips_pkg::FN_ADD;
						1: w.r.funct = mips_pkg::FN_SUB;
						2: w.r.funct = mips_pkg::FN_AND;
						3: w.r.funct = mips_pkg::FN_OR;
						default: w.r.funct = mips_pkg::FN_SLT;
					endcase
				end
				5: w.i.opcode = mips_pkg::OP_ADDI;
				6, 7: begin
					// word address is r0 plus a small aligned offset
					w.i.opcode = ((pick % 9) == 6) ? mips_pkg::OP_LW : mips_pkg::OP_SW;
					w.i.rs     = '0;
					w.i.imm16  = {8'h00, r[5:0], 2'b00};
				end
				default: w.i.opcode = mips_pkg::OP_BEQ;
			endcase
		end
		return w;
	endfunction

	// =========================================================================
	// reference model
	// =========================================================================
	task automatic issue_model(input int k, input mips_pkg::instr_t w,
			input logic [mips_pkg::XLEN-1:0] npc);
		logic [mips_pkg::XLEN-1:0]        a;
		logic [mips_pkg::XLEN-1:0]        b;
		logic [mips_pkg::XLEN-1:0]        sext;
		logic [mips_pkg::XLEN-1:0]        addr;
		logic [mips_pkg::XLEN-1:0]        res;
		logic [mips_pkg::DMEM_ADDR_W-1:0] word;
		// result on the writeback port now is seen by this read
		if (exp_wb_en[k] && (exp_wb_reg[k] != '0)) begin
			model_regs[exp_wb_reg[k]] = exp_wb_data[k];
		end
		a    = model_regs[w.r.rs];
		b    = model_regs[w.r.rt];
		sext = {{16{w.i.imm16[15]}}, w.i.imm16};
		addr = a + sext;
		word = addr[7:2];
		case (w.r.opcode)
			mips_pkg::OP_RTYPE: begin
				case (w.r.funct)
					mips_pkg::FN_SUB: res = a - b;
					mips_pkg::FN_AND: res = a & b;
					mips_pkg::FN_OR:  res = a | b;
					mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:          res = a + b;
				endcase
				exp_wb_en[k+3]   = 1'b1;
				exp_wb_reg[k+3]  = w.r.rd;
				exp_wb_data[k+3] = res;
			end
			mips_pkg::OP_ADDI: begin
				exp_wb_en[k+3]   = 1'b1;
				exp_wb_reg[k+3]  = w.i.rt;
				exp_wb_data[k+3] = addr;
			end
			mips_pkg::OP_LW: begin
				exp_wb_en[k+3]   = 1'b1;
				exp_wb_reg[k+3]  = w.i.rt;
				exp_wb_data[k+3] = model_ram[word];
			end
			mips_pkg::OP_SW: model_ram[word] = b;
			mips_pkg::OP_BEQ: begin
				exp_br_valid[k+2]  = 1'b1;
				exp_br_taken[k+2]  = (a == b);
				exp_br_target[k+2] = npc + (sext << 2);
			end
			default: begin
			end
		endcase
	endtask

	// =========================================================================
	// compare tasks
	// =========================================================================
	task automatic check_wb(input logic en_exp, input logic [mips_pkg::REG_ADDR_W-1:0] reg_exp,
			input logic [mips_pkg::XLEN-1:0] data_exp);
		if (o_wb_en !== en_exp) begin
			$display("CHECK FAILED at %0t: o_wb_en got %b expected %b", $time, o_wb_en, en_exp);
			wb_errors++;
		end else if (en_exp) begin
			if (o_wb_reg !== reg_exp) begin
				$display("CHECK FAILED at %0t: o_wb_reg got %0d expected %0d",
					$time, o_wb_reg, reg_exp);
				wb_errors++;
			end
			if (o_wb_data !== data_exp) begin
				$display("CHECK FAILED at %0t: o_wb_data got %h expected %h",
					$time, o_wb_data, data_exp);
				wb_errors++;
			end
		end
	endtask

	task automatic check_branch(input logic taken_exp, input logic is_beq,
			input logic [mips_pkg::XLEN-1:0] target_exp);
		if (o_branch_taken !== taken_exp) begin
			$display("CHECK FAILED at %0t: o_branch_taken got %b expected %b",
				$time, o_branch_taken, taken_exp);
			br_errors++;
		end
		if (is_beq && (o_branch_target !== target_exp)) begin
			$display("CHECK FAILED at %0t: o_branch_target got %h expected %h",
				$time, o_branch_target, target_exp);
			br_errors++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge i_clk) begin
		if (checking) begin
			check_wb(exp_wb_en[cyc], exp_wb_reg[cyc], exp_wb_data[cyc]);
			check_branch(exp_br_taken[cyc], exp_br_valid[cyc], exp_br_target[cyc]);
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not complete within %0d ns", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		mips_pkg::instr_t          w;
		logic [mips_pkg::XLEN-1:0] pc;
		i_clk     = 1'b0;
		i_rst_n   = 1'b0;
		i_instr   = BUBBLE_WORD;
		i_next_pc = '0;
		rng_state = 32'h1749ccd9;
		cyc       = 0;
		checking  = 1'b0;
		wb_errors = 0;
		br_errors = 0;
		for (int i = 0; i < 2**mips_pkg::REG_ADDR_W; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < mips_pkg::DMEM_DEPTH; i++) begin
			model_ram[i] = '0;
		end
		for (int i = 0; i < NUM_CYCLES; i++) begin
			exp_wb_en[i]     = 1'b0;
			exp_wb_reg[i]    = '0;
			exp_wb_data[i]   = '0;
			exp_br_taken[i]  = 1'b0;
			exp_br_valid[i]  = 1'b0;
			exp_br_target[i] = '0;
		end
		repeat (10) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		for (int k = 0; k < NUM_CYCLES; k++) begin
			@(posedge i_clk);
			#1;
			cyc      = k;
			checking = 1'b1;
			if (k < NUM_INSTR) begin
				w  = make_instr();
				pc = next_random();
				issue_model(k, w, pc);
				i_instr   = w;
				i_next_pc = pc;
			end else begin
				// drain the pipeline
				i_instr   = BUBBLE_WORD;
				i_next_pc = '0;
			end
		end
		@(negedge i_clk);
		#1;
		checking = 1'b0;
		$display("errors: writeback %0d, branch %0d, total %0d",
			wb_errors, br_errors, wb_errors + br_errors);
		if ((wb_errors + br_errors) == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- mips_core.sv
`timescale 1ns/1ps

module mips_core (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  mips_pkg::instr_t                i_instr,
	input  logic [mips_pkg::XLEN-1:0]       i_next_pc,
	output logic                            o_branch_taken,
	output logic [mips_pkg::XLEN-1:0]       o_branch_target,
	output logic                            o_wb_en,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_wb_reg,
	output logic [mips_pkg::XLEN-1:0]       o_wb_data
);

	// control from main control
	logic [5:0] opcode;
	logic       regdst, alusrc, branch, memread, memwrite, memtoreg, regwrite;
	logic [1:0] aluop;

	// decode/execute
	logic                            ex_regdst, ex_alusrc, ex_branch, ex_memread;
	logic                            ex_memwrite, ex_memtoreg, ex_regwrite;
	logic [1:0]                      ex_aluop;
	logic [mips_pkg::XLEN-1:0]       ex_next_pc, ex_rs_data, ex_rt_data, ex_sign_ext;
	logic [mips_pkg::REG_ADDR_W-1:0] ex_rt, ex_rd;
	logic [5:0]                      ex_funct;

	// execute/memory
	logic [mips_pkg::XLEN-1:0]       mem_alu_result, mem_store_data;
	logic [mips_pkg::REG_ADDR_W-1:0] mem_wr_reg;
	logic                            mem_memread, mem_memwrite, mem_memtoreg, mem_regwrite;

	// memory/writeback
	logic [mips_pkg::XLEN-1:0]       wb_alu_result, wb_load_data;
	logic [mips_pkg::REG_ADDR_W-1:0] wb_reg;
	logic                            wb_memtoreg, wb_regwrite;

	// =========================================================================
	// writeback select
	// =========================================================================
	assign o_wb_en   = wb_regwrite;
	assign o_wb_reg  = wb_reg;
	assign o_wb_data = wb_memtoreg ? wb_load_data : wb_alu_result;

	main_control u_main_control (
		.i_opcode (opcode), .o_regdst (regdst), .o_alusrc (alusrc),
		.o_branch (branch), .o_memread (memread), .o_memwrite (memwrite),
		.o_memtoreg (memtoreg), .o_regwrite (regwrite), .o_aluop (aluop)
	);

	decode_stage u_decode_stage (
		.i_clk (i_clk), .i_rst_n (i_rst_n), .i_instr (i_instr), .i_next_pc (i_next_pc),
		.i_regdst (regdst), .i_alusrc (alusrc), .i_branch (branch),
		.i_memread (memread), .i_memwrite (memwrite), .i_memtoreg (memtoreg),
		.i_regwrite (regwrite), .i_aluop (aluop),
		.i_wb_en (o_wb_en), .i_wb_reg (o_wb_reg), .i_wb_data (o_wb_data),
		.o_opcode (opcode),
		.o_ex_regdst (ex_regdst), .o_ex_alusrc (ex_alusrc), .o_ex_branch (ex_branch),
		.o_ex_memread (ex_memread), .o_ex_memwrite (ex_memwrite),
		.o_ex_memtoreg (ex_memtoreg), .o_ex_regwrite (ex_regwrite), .o_ex_aluop (ex_aluop),
		.o_ex_next_pc (ex_next_pc), .o_ex_rs_data (ex_rs_data), .o_ex_rt_data (ex_rt_data),
		.o_ex_sign_ext (ex_sign_ext), .o_ex_rt (ex_rt), .o_ex_rd (ex_rd),
		.o_ex_funct (ex_funct)
	);

	execute_stage u_execute_stage (
		.i_clk (i_clk), .i_rst_n (i_rst_n),
		.i_ex_regdst (ex_regdst), .i_ex_alusrc (ex_alusrc), .i_ex_branch (ex_branch),
		.i_ex_memread (ex_memread), .i_ex_memwrite (ex_memwrite),
		.i_ex_memtoreg (ex_memtoreg), .i_ex_regwrite (ex_regwrite), .i_ex_aluop (ex_aluop),
		.i_ex_next_pc (ex_next_pc), .i_ex_rs_data (ex_rs_data), .i_ex_rt_data (ex_rt_data),
		.i_ex_sign_ext (ex_sign_ext), .i_ex_rt (ex_rt), .i_ex_rd (ex_rd),
		.i_ex_funct (ex_funct),
		.o_mem_alu_result (mem_alu_result), .o_mem_store_data (mem_store_data),
		.o_mem_wr_reg (mem_wr_reg), .o_mem_memread (mem_memread),
		.o_mem_memwrite (mem_memwrite), .o_mem_memtoreg (mem_memtoreg),
		.o_mem_regwrite (mem_regwrite),
		.o_branch_taken (o_branch_taken), .o_branch_target (o_branch_target)
	);

	memory_stage u_memory_stage (
		.i_clk (i_clk), .i_rst_n (i_rst_n),
		.i_mem_alu_result (mem_alu_result), .i_mem_store_data (mem_store_data),
		.i_mem_wr_reg (mem_wr_reg), .i_mem_memread (mem_memread),
		.i_mem_memwrite (mem_memwrite), .i_mem_memtoreg (mem_memtoreg),
		.i_mem_regwrite (mem_regwrite),
		.o_wb_alu_result (wb_alu_result), .o_wb_load_data (wb_load_data),
		.o_wb_reg (wb_reg), .o_wb_memtoreg (wb_memtoreg), .o_wb_regwrite (wb_regwrite)
	);

endmodule

//--- memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  logic [mips_pkg::XLEN-1:0]       i_mem_alu_result,
	input  logic [mips_pkg::XLEN-1:0]       i_mem_store_data,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_mem_wr_reg,
	input  logic                            i_mem_memread,
	input  logic                            i_mem_memwrite,
	input  logic                            i_mem_memtoreg,
	input  logic                            i_mem_regwrite,
	output logic [mips_pkg::XLEN-1:0]       o_wb_alu_result,
	output logic [mips_pkg::XLEN-1:0]       o_wb_load_data,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_wb_reg,
	output logic                            o_wb_memtoreg,
	output logic                            o_wb_regwrite
);

	logic [mips_pkg::XLEN-1:0]        ram [mips_pkg::DMEM_DEPTH];
	logic [mips_pkg::DMEM_ADDR_W-1:0] word_addr;
	logic [mips_pkg::XLEN-1:0]        rd_data;

	// byte address to word index
	assign word_addr = i_mem_alu_result[mips_pkg::DMEM_ADDR_W+1:2];
	assign rd_data   = i_mem_memread ? ram[word_addr] : '0;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < mips_pkg::DMEM_DEPTH; i++) begin
				ram[i] <= '0;
			end
		end else if (i_mem_memwrite) begin
			ram[word_addr] <= i_mem_store_data;
		end
	end

	// memory/writeback register
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wb_alu_result <= '0;
			o_wb_load_data  <= '0;
			o_wb_reg        <= '0;
			o_wb_memtoreg   <= 1'b0;
			o_wb_regwrite   <= 1'b0;
		end else begin
			o_wb_alu_result <= i_mem_alu_result;
			o_wb_load_data  <= rd_data;
			o_wb_reg        <= i_mem_wr_reg;
			o_wb_memtoreg   <= i_mem_memtoreg;
			o_wb_regwrite   <= i_mem_regwrite;
		end
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  logic                            i_ex_regdst,
	input  logic                            i_ex_alusrc,
	input  logic                            i_ex_branch,
	input  logic                            i_ex_memread,
	input  logic                            i_ex_memwrite,
	input  logic                            i_ex_memtoreg,
	input  logic                            i_ex_regwrite,
	input  logic [1:0]                      i_ex_aluop,
	input  logic [mips_pkg::XLEN-1:0]       i_ex_next_pc,
	input  logic [mips_pkg::XLEN-1:0]       i_ex_rs_data,
	input  logic [mips_pkg::XLEN-1:0]       i_ex_rt_data,
	input  logic [mips_pkg::XLEN-1:0]       i_ex_sign_ext,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_rt,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_rd,
	input  logic [5:0]                      i_ex_funct,
	// execute/memory boundary
	output logic [mips_pkg::XLEN-1:0]       o_mem_alu_result,
	output logic [mips_pkg::XLEN-1:0]       o_mem_store_data,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_mem_wr_reg,
	output logic                            o_mem_memread,
	output logic                            o_mem_memwrite,
	output logic                            o_mem_memtoreg,
	output logic                            o_mem_regwrite,
	output logic                            o_branch_taken,
	output logic [mips_pkg::XLEN-1:0]       o_branch_target
);

	logic [2:0]                      alu_sel;
	logic [mips_pkg::XLEN-1:0]       alu_b;
	logic [mips_pkg::XLEN-1:0]       alu_result;
	logic [mips_pkg::XLEN-1:0]       target;
	logic [mips_pkg::REG_ADDR_W-1:0] wr_reg;

	// =========================================================================
	// alu control
	// =========================================================================
	always_comb begin
		case (i_ex_aluop)
			mips_pkg::ALUOP_SUB: alu_sel = mips_pkg::ALU_SUB;
			mips_pkg::ALUOP_FUNCT: begin
				case (i_ex_funct)
					mips_pkg::FN_SUB: alu_sel = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_sel = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  alu_sel = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT: alu_sel = mips_pkg::ALU_SLT;
					default:          alu_sel = mips_pkg::ALU_ADD;
				endcase
			end
			default: alu_sel = mips_pkg::ALU_ADD;
		endcase
	end

	// =========================================================================
	// alu and branch
	// =========================================================================
	assign alu_b  = i_ex_alusrc ? i_ex_sign_ext : i_ex_rt_data;
	assign wr_reg = i_ex_regdst ? i_ex_rd : i_ex_rt;
	// word offset relative to pc+4
	assign target = i_ex_next_pc + {i_ex_sign_ext[mips_pkg::XLEN-3:0], 2'b00};

	always_comb begin
		case (alu_sel)
			mips_pkg::ALU_SUB: alu_result = i_ex_rs_data - alu_b;
			mips_pkg::ALU_AND: alu_result = i_ex_rs_data & alu_b;
			mips_pkg::ALU_OR:  alu_result = i_ex_rs_data | alu_b;
			mips_pkg::ALU_SLT: begin
				alu_result = {{(mips_pkg::XLEN-1){1'b0}},
					$signed(i_ex_rs_data) < $signed(alu_b)};
			end
			default: alu_result = i_ex_rs_data + alu_b;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_mem_alu_result <= '0;
			o_mem_store_data <= '0;
			o_mem_wr_reg     <= '0;
			o_mem_memread    <= 1'b0;
			o_mem_memwrite   <= 1'b0;
			o_mem_memtoreg   <= 1'b0;
			o_mem_regwrite   <= 1'b0;
			o_branch_taken   <= 1'b0;
			o_branch_target  <= '0;
		end else begin
			o_mem_alu_result <= alu_result;
			o_mem_store_data <= i_ex_rt_data;
			o_mem_wr_reg     <= wr_reg;
			o_mem_memread    <= i_ex_memread;
			o_mem_memwrite   <= i_ex_memwrite;
			o_mem_memtoreg   <= i_ex_memtoreg;
			o_mem_regwrite   <= i_ex_regwrite;
			o_branch_taken   <= i_ex_branch && (alu_result == '0);
			o_branch_target  <= target;
		end
	end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  mips_pkg::instr_t                i_instr,
	input  logic [mips_pkg::XLEN-1:0]       i_next_pc,
	// from main control
	input  logic                            i_regdst,
	input  logic                            i_alusrc,
	input  logic                            i_branch,
	input  logic                            i_memread,
	input  logic                            i_memwrite,
	input  logic                            i_memtoreg,
	input  logic                            i_regwrite,
	input  logic [1:0]                      i_aluop,
	// writeback port
	input  logic                            i_wb_en,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_wb_reg,
	input  logic [mips_pkg::XLEN-1:0]       i_wb_data,
	output logic [5:0]                      o_opcode,
	// decode/execute boundary
	output logic                            o_ex_regdst,
	output logic                            o_ex_alusrc,
	output logic                            o_ex_branch,
	output logic                            o_ex_memread,
	output logic                            o_ex_memwrite,
	output logic                            o_ex_memtoreg,
	output logic                            o_ex_regwrite,
	output logic [1:0]                      o_ex_aluop,
	output logic [mips_pkg::XLEN-1:0]       o_ex_next_pc,
	output logic [mips_pkg::XLEN-1:0]       o_ex_rs_data,
	output logic [mips_pkg::XLEN-1:0]       o_ex_rt_data,
	output logic [mips_pkg::XLEN-1:0]       o_ex_sign_ext,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rt,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rd,
	output logic [5:0]                      o_ex_funct
);

	logic [mips_pkg::XLEN-1:0] rs_data;
	logic [mips_pkg::XLEN-1:0] rt_data;
	logic [mips_pkg::XLEN-1:0] sign_ext;

	assign o_opcode = i_instr.r.opcode;
	assign sign_ext = {{(mips_pkg::XLEN-16){i_instr.i.imm16[15]}}, i_instr.i.imm16};

	register_bank u_register_bank (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_rs_addr (i_instr.r.rs),
		.i_rt_addr (i_instr.r.rt),
		.i_wr_en   (i_wb_en),
		.i_wr_addr (i_wb_reg),
		.i_wr_data (i_wb_data),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	// =========================================================================
	// decode/execute register
	// =========================================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ex_regdst   <= 1'b0;
			o_ex_alusrc   <= 1'b0;
			o_ex_branch   <= 1'b0;
			o_ex_memread  <= 1'b0;
			o_ex_memwrite <= 1'b0;
			o_ex_memtoreg <= 1'b0;
			o_ex_regwrite <= 1'b0;
			o_ex_aluop    <= '0;
			o_ex_next_pc  <= '0;
			o_ex_rs_data  <= '0;
			o_ex_rt_data  <= '0;
			o_ex_sign_ext <= '0;
			o_ex_rt       <= '0;
			o_ex_rd       <= '0;
			o_ex_funct    <= '0;
		end else begin
			o_ex_regdst   <= i_regdst;
			o_ex_alusrc   <= i_alusrc;
			o_ex_branch   <= i_branch;
			o_ex_memread  <= i_memread;
			o_ex_memwrite <= i_memwrite;
			o_ex_memtoreg <= i_memtoreg;
			o_ex_regwrite <= i_regwrite;
			o_ex_aluop    <= i_aluop;
			o_ex_next_pc  <= i_next_pc;
			o_ex_rs_data  <= rs_data;
			o_ex_rt_data  <= rt_data;
			o_ex_sign_ext <= sign_ext;
			o_ex_rt       <= i_instr.r.rt;
			o_ex_rd       <= i_instr.r.rd;
			o_ex_funct    <= i_instr.r.funct;
		end
	end

endmodule

//--- register_bank.sv
`timescale 1ns/1ps

module register_bank (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_rs_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_rt_addr,
	input  logic                            i_wr_en,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_wr_addr,
	input  logic [mips_pkg::XLEN-1:0]       i_wr_data,
	output logic [mips_pkg::XLEN-1:0]       o_rs_data,
	output logic [mips_pkg::XLEN-1:0]       o_rt_data
);

	logic [mips_pkg::XLEN-1:0] regs [2**mips_pkg::REG_ADDR_W];
	logic                      wr_live;

	// register 0 is never a real write target
	assign wr_live = i_wr_en && (i_wr_addr != '0);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 2**mips_pkg::REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// write-through so writeback in this cycle is seen by decode
	always_comb begin
		if (i_rs_addr == '0) begin
			o_rs_data = '0;
		end else if (wr_live && (i_wr_addr == i_rs_addr)) begin
			o_rs_data = i_wr_data;
		end else begin
			o_rs_data = regs[i_rs_addr];
		end
		if (i_rt_addr == '0) begin
			o_rt_data = '0;
		end else if (wr_live && (i_wr_addr == i_rt_addr)) begin
			o_rt_data = i_wr_data;
		end else begin
			o_rt_data = regs[i_rt_addr];
		end
	end

endmodule

//--- main_control.sv
`timescale 1ns/1ps

module main_control (
	input  logic [5:0] i_opcode,
	output logic       o_regdst,
	output logic       o_alusrc,
	output logic       o_branch,
	output logic       o_memread,
	output logic       o_memwrite,
	output logic       o_memtoreg,
	output logic       o_regwrite,
	output logic [1:0] o_aluop
);

	always_comb begin
		// anything not listed below becomes a bubble
		o_regdst   = 1'b0;
		o_alusrc   = 1'b0;
		o_branch   = 1'b0;
		o_memread  = 1'b0;
		o_memwrite = 1'b0;
		o_memtoreg = 1'b0;
		o_regwrite = 1'b0;
		o_aluop    = mips_pkg::ALUOP_ADD;
		case (i_opcode)
			mips_pkg::OP_RTYPE: begin
				o_regdst   = 1'b1;
				o_regwrite = 1'b1;
				o_aluop    = mips_pkg::ALUOP_FUNCT;
			end
			mips_pkg::OP_ADDI: begin
				o_alusrc   = 1'b1;
				o_regwrite = 1'b1;
			end
			mips_pkg::OP_LW: begin
				o_alusrc   = 1'b1;
				o_memread  = 1'b1;
				o_memtoreg = 1'b1;
				o_regwrite = 1'b1;
			end
			mips_pkg::OP_SW: begin
				o_alusrc   = 1'b1;
				o_memwrite = 1'b1;
			end
			// compare by subtraction in execute
			mips_pkg::OP_BEQ: begin
				o_branch = 1'b1;
				o_aluop  = mips_pkg::ALUOP_SUB;
			end
			default: begin
				o_aluop = mips_pkg::ALUOP_ADD;
			end
		endcase
	end

endmodule

//--- mips_pkg.sv
package mips_pkg;

	// =========================================================================
	// widths and sizes
	// =========================================================================
	localparam int XLEN        = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int DMEM_DEPTH  = 64;
	localparam int DMEM_ADDR_W = 6;

	// =========================================================================
	// instruction encodings
	// =========================================================================
	// primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;

	// funct field for r-type
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// alu request from main control
	localparam logic [1:0] ALUOP_ADD   = 2'b00;
	localparam logic [1:0] ALUOP_SUB   = 2'b01;
	localparam logic [1:0] ALUOP_FUNCT = 2'b10;

	// alu operation select
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR  = 3'd3;
	localparam logic [2:0] ALU_SLT = 3'd4;

	// one instruction word seen as r-format or i-format
	typedef union packed {
		struct packed {
			logic [5:0]            opcode;
			logic [REG_ADDR_W-1:0] rs;
			logic [REG_ADDR_W-1:0] rt;
			logic [REG_ADDR_W-1:0] rd;
			logic [4:0]            shamt;
			logic [5:0]            funct;
		} r;
		struct packed {
			logic [5:0]            opcode;
			logic [REG_ADDR_W-1:0] rs;
			logic [REG_ADDR_W-1:0] rt;
			logic [15:0]           imm16;
		} i;
	} instr_t;

endpackage
